// File: all.f
src/pwm_cfg_pkg.sv
src/pwm_cmd_pkg.sv
src/pwm_cmd_decoder.sv
src/pwm_channel_regs.sv
src/pwm_generator.sv
src/pwm_top.sv
verification/pwm_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the pwm testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module pwm_tb -f all.f -o pwm_sim

./obj_dir/pwm_sim > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation finished without a failure"
exit 0

// File: verification/pwm_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pwm_tb;

	import pwm_cfg_pkg::*;
	import pwm_cmd_pkg::*;

	localparam int RESET_CYC = 10;
	localparam int IDLE_CYC = 40;
	localparam int DUTY_CYC = 400;
	localparam int CONST_CYC = 250;
	localparam int SCHED_CYC = 450;
	localparam int SAFE_CYC = 500;
	localparam int INDEP_ROUNDS = 4;
	localparam int INDEP_CYC = 260;
	// 29 commands at up to 8 cycles each
	localparam int CMD_BUDGET = 29 * 8;
	localparam int TIMEOUT_CYC = RESET_CYC + IDLE_CYC + DUTY_CYC + CONST_CYC + SCHED_CYC
		+ SAFE_CYC + INDEP_ROUNDS * INDEP_CYC + CMD_BUDGET + 2000;

	localparam logic [31:0] CYC_MIN = 32'd4;
	localparam logic [31:0] CYC_MAX = 32'd40;
	// longer than one old period plus one new period
	localparam logic [31:0] SETTLE = 32'd88;
	localparam logic [31:0] TICK_MAX = (32'd1 << PWM_BITS) - 32'd1;

	logic                clk = 1'b0;
	logic                rst_n;
	logic [31:0]         systime = 32'd0;
	logic [CMD_BITS-1:0] cmd;
	logic                cmd_ready;
	logic [31:0]         arg_data;
	logic                cmd_done;
	logic [NPWM-1:0]     pwm;

	int          errors = 0;
	int          commands = 0;
	int          cycles = 0;
	logic [31:0] rng = 32'hfc00_b044;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic [2:0]          seq;
	logic [CMD_BITS-1:0] cur_cmd;
	logic [CH_BITS-1:0]  cur_ch;
	logic [2:0]          done_cnt;
	logic [31:0]         runs_checked;
	logic [31:0]         exp_cyc [NPWM];
	logic [31:0]         exp_on [NPWM];
	logic [31:0]         maxd [NPWM];
	logic [31:0]         ntime [NPWM];
	logic [31:0]         non [NPWM];
	logic [31:0]         dur [NPWM];
	logic [31:0]         quiet [NPWM];
	logic [31:0]         run_len [NPWM];
	logic [31:0]         exp_run [NPWM];
	logic [NPWM-1:0]     dflt;
	logic [NPWM-1:0]     armed;
	logic [NPWM-1:0]     prev_pwm;
	logic [NPWM-1:0]     duty;
	logic [NPWM-1:0]     lvl;
	logic [NPWM-1:0]     clean;

	pwm_top dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.systime   (systime),
		.cmd       (cmd),
		.cmd_ready (cmd_ready),
		.arg_data  (arg_data),
		.cmd_done  (cmd_done),
		.pwm       (pwm)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	always @(negedge clk) begin
		systime <= systime + 32'd1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] tick_of(input logic [31:0] word);
		return word & TICK_MAX;
	endfunction

	// expected mode per channel
	// a compare outside 1..C-1 never toggles
	always_comb begin
		for (int i = 0; i < NPWM; i++) begin
			duty[i] = (exp_on[i] != 32'd0) && (exp_on[i] < exp_cyc[i]);
			lvl[i] = (exp_on[i] != 32'd0);
			exp_run[i] = prev_pwm[i] ? exp_cyc[i] - exp_on[i] : exp_on[i];
			clean[i] = duty[i] && (quiet[i] >= run_len[i] + SETTLE);
		end
	end

	always @(posedge clk) begin
		logic [NPWM-1:0] chg;
		logic [31:0]     nruns;
		chg = '0;
		nruns = 32'd0;
		if (!rst_n) begin
			seq <= 3'd0;
			cur_cmd <= '0;
			cur_ch <= '0;
			done_cnt <= 3'd0;
			runs_checked <= 32'd0;
			dflt <= '0;
			armed <= '0;
			prev_pwm <= '0;
			for (int i = 0; i < NPWM; i++) begin
				exp_cyc[i] <= 32'd0;
				exp_on[i] <= 32'd0;
				maxd[i] <= 32'd0;
				ntime[i] <= 32'd0;
				non[i] <= 32'd0;
				dur[i] <= 32'd0;
				quiet[i] <= SETTLE + SETTLE;
				run_len[i] <= 32'd0;
			end
		end else begin
			if (done_cnt != 3'd0) begin
				done_cnt <= done_cnt - 3'd1;
			end
			if (seq != 3'd0) begin
				// one argument word per clock after the channel word
				if (cur_cmd == CMD_CONFIG_PWM) begin
					case (seq)
						3'd1: exp_cyc[cur_ch] <= tick_of(arg_data);
						3'd2: exp_on[cur_ch] <= tick_of(arg_data);
						3'd3: dflt[cur_ch] <= arg_data[0];
						default: maxd[cur_ch] <= arg_data;
					endcase
					chg[cur_ch] = (seq < 3'd3);
				end else if (seq == 3'd1) begin
					ntime[cur_ch] <= arg_data;
				end else begin
					non[cur_ch] <= tick_of(arg_data);
					armed[cur_ch] <= 1'b1;
				end
				seq <= (seq == ((cur_cmd == CMD_CONFIG_PWM) ? 3'd4 : 3'd2)) ? 3'd0 : seq + 3'd1;
			end else if (cmd_ready && done_cnt == 3'd0) begin
				cur_cmd <= cmd;
				cur_ch <= arg_data[CH_BITS-1:0];
				if (cmd == CMD_CONFIG_PWM) begin
					seq <= 3'd1;
					done_cnt <= 3'd5;
				end else if (cmd == CMD_SCHEDULE_PWM) begin
					seq <= 3'd1;
					done_cnt <= 3'd3;
				end else begin
					done_cnt <= 3'd1;
				end
			end
			for (int i = 0; i < NPWM; i++) begin
				// expiry forces the default but a load in the same cycle wins
				if (dur[i] == 32'd1) begin
					exp_on[i] <= dflt[i] ? TICK_MAX : 32'd0;
					chg[i] = 1'b1;
				end
				if (dur[i] != 32'd0) begin
					dur[i] <= dur[i] - 32'd1;
				end
				if (armed[i] && ntime[i] == systime) begin
					exp_on[i] <= non[i];
					dur[i] <= maxd[i];
					armed[i] <= 1'b0;
					chg[i] = 1'b1;
				end
				quiet[i] <= chg[i] ? 32'd0 : quiet[i] + 32'd1;
				if (pwm[i] != prev_pwm[i]) begin
					run_len[i] <= 32'd1;
					if (clean[i]) begin
						nruns = nruns + 32'd1;
					end
				end else begin
					run_len[i] <= run_len[i] + 32'd1;
				end
			end
			prev_pwm <= pwm;
			runs_checked <= runs_checked + nruns;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assert property (@(posedge clk) disable iff (!rst_n) cmd_done == (done_cnt == 3'd1))
	else begin
		errors++;
		$display("MISMATCH cmd_done: expected %h, got %h",
			$sampled(done_cnt == 3'd1), $sampled(cmd_done));
	end

	for (genvar g = 0; g < NPWM; g++) begin : g_check
		assert property (@(posedge clk) disable iff (!rst_n)
			(pwm[g] != prev_pwm[g]) && clean[g] |-> run_len[g] == exp_run[g])
		else begin
			errors++;
			$display("MISMATCH pwm[%0d] run length: expected %h, got %h", g,
				$sampled(exp_run[g]), $sampled(run_len[g]));
		end

		// steady low or high once the last change has worked through
		assert property (@(posedge clk) disable iff (!rst_n)
			!duty[g] && quiet[g] >= SETTLE |-> pwm[g] == lvl[g])
		else begin
			errors++;
			$display("MISMATCH pwm[%0d]: expected %h, got %h", g,
				$sampled(lvl[g]), $sampled(pwm[g]));
		end

		assert property (@(posedge clk) disable iff (!rst_n)
			duty[g] && quiet[g] >= SETTLE + SETTLE |-> run_len[g] < SETTLE)
		else begin
			errors++;
			$display("channel %0d stopped toggling although a duty is programmed", g);
		end
	end

	task automatic finish_run(input bit timed_out);
		if (runs_checked == 32'd0) begin
			$display("no pwm run length was ever checked");
		end
		$display("errors=%0d commands=%0d runs_checked=%0d cycles=%0d",
			errors, commands, runs_checked, cycles);
		if (errors == 0 && !timed_out && runs_checked != 32'd0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYC);
			finish_run(1'b1);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic send_command(input logic [CMD_BITS-1:0] code, input logic [CH_BITS-1:0] ch,
		input int nargs, input logic [31:0] w0, w1, w2, w3);
		logic [31:0] words [4];
		words = '{w0, w1, w2, w3};
		@(negedge clk);
		cmd = code;
		cmd_ready = 1'b1;
		arg_data = 32'(ch);
		for (int k = 0; k < nargs; k++) begin
			@(negedge clk);
			cmd_ready = 1'b0;
			arg_data = words[k];
		end
		@(negedge clk);
		cmd_ready = 1'b0;
		arg_data = 32'd0;
		while (!cmd_done) @(negedge clk);
		commands++;
	endtask

	task automatic configure_channel(input logic [CH_BITS-1:0] ch, input logic [31:0] c, o,
		dlvl, maxdur);
		send_command(CMD_CONFIG_PWM, ch, 4, c, o, dlvl, maxdur);
	endtask

	task automatic schedule_channel(input logic [CH_BITS-1:0] ch, input logic [31:0] delay, o);
		send_command(CMD_SCHEDULE_PWM, ch, 2, systime + delay, o, 32'd0, 32'd0);
	endtask

	task automatic draw_compare(input logic [31:0] c, output logic [31:0] o);
		rng = xorshift32(rng);
		o = 32'd1 + rng % (c - 32'd1);
	endtask

	task automatic random_duty(output logic [31:0] c, output logic [31:0] o);
		rng = xorshift32(rng);
		c = CYC_MIN + rng % (CYC_MAX - CYC_MIN + 32'd1);
		draw_compare(c, o);
	endtask

	task automatic pick_channel(output logic [CH_BITS-1:0] ch);
		rng = xorshift32(rng);
		ch = CH_BITS'(rng % 32'(NPWM));
	endtask

	initial begin
		logic [31:0]        c;
		logic [31:0]        o;
		logic [CH_BITS-1:0] ch;
		logic [CH_BITS-1:0] ch_b;
		cmd = '0;
		cmd_ready = 1'b0;
		arg_data = 32'd0;
		rst_n = 1'b0;
		repeat (RESET_CYC) @(negedge clk);
		rst_n = 1'b1;
		repeat (IDLE_CYC) @(negedge clk);
		send_command(8'h7e, 4'd5, 0, 32'd0, 32'd0, 32'd0, 32'd0);

		for (int i = 0; i < NPWM; i++) begin
			random_duty(c, o);
			configure_channel(CH_BITS'(i), c, o, 32'd0, 32'd0);
		end
		repeat (DUTY_CYC) @(negedge clk);

		// compare 0 and compare all ones on neighbouring channels
		pick_channel(ch);
		ch_b = (ch == 4'd11) ? 4'd0 : ch + 4'd1;
		configure_channel(ch, 32'd30, 32'd0, 32'd0, 32'd0);
		configure_channel(ch_b, 32'd30, TICK_MAX, 32'd0, 32'd0);
		repeat (CONST_CYC) @(negedge clk);

		// scheduled compare without a timeout
		pick_channel(ch);
		random_duty(c, o);
		configure_channel(ch, c, o, 32'd0, 32'd0);
		draw_compare(c, o);
		schedule_channel(ch, 32'd100, o);
		repeat (SCHED_CYC) @(negedge clk);

		// safety timer with one channel falling back high and one low
		pick_channel(ch);
		ch_b = (ch == 4'd11) ? 4'd0 : ch + 4'd1;
		random_duty(c, o);
		configure_channel(ch, c, o, 32'd1, 32'd150);
		configure_channel(ch_b, c, o, 32'd0, 32'd120);
		draw_compare(c, o);
		schedule_channel(ch, 32'd60, o);
		schedule_channel(ch_b, 32'd60, o);
		repeat (SAFE_CYC) @(negedge clk);

		for (int n = 0; n < INDEP_ROUNDS; n++) begin
			pick_channel(ch);
			random_duty(c, o);
			configure_channel(ch, c, o, 32'd0, 32'd0);
			draw_compare(c, o);
			schedule_channel(ch, 32'd60, o);
			repeat (INDEP_CYC) @(negedge clk);
		end
		finish_run(1'b0);
	end

endmodule

`default_nettype wire

// File: src/pwm_top.sv
`timescale 1ns/1ns
`default_nettype none

module pwm_top (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [31:0]                        systime,
	input  logic [pwm_cmd_pkg::CMD_BITS-1:0]   cmd,
	input  logic                               cmd_ready,
	input  logic [31:0]                        arg_data,
	output logic                               cmd_done,
	output logic [pwm_cfg_pkg::NPWM-1:0]       pwm
);

	import pwm_cfg_pkg::*;
	import pwm_cmd_pkg::*;

	// decoder to register block
	logic               wr_en;
	logic [CH_BITS-1:0] wr_channel;
	cfg_field_e         wr_field;
	arg_word_u          wr_data;

	// register block to generator
	logic [NPWM-1:0][PWM_BITS-1:0] cycle_ticks;
	logic [NPWM-1:0][PWM_BITS-1:0] on_ticks;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// command path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	pwm_cmd_decoder u_decoder (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd        (cmd),
		.cmd_ready  (cmd_ready),
		.arg_data   (arg_data),
		.cmd_done   (cmd_done),
		.wr_en      (wr_en),
		.wr_channel (wr_channel),
		.wr_field   (wr_field),
		.wr_data    (wr_data)
	);

	pwm_channel_regs u_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.systime     (systime),
		.wr_en       (wr_en),
		.wr_channel  (wr_channel),
		.wr_field    (wr_field),
		.wr_data     (wr_data),
		.cycle_ticks (cycle_ticks),
		.on_ticks    (on_ticks)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output stage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	pwm_generator u_generator (
		.clk         (clk),
		.rst_n       (rst_n),
		.cycle_ticks (cycle_ticks),
		.on_ticks    (on_ticks),
		.pwm         (pwm)
	);

endmodule

`default_nettype wire

// File: src/pwm_generator.sv
`timescale 1ns/1ns
`default_nettype none

module pwm_generator (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic [pwm_cfg_pkg::NPWM-1:0][pwm_cfg_pkg::PWM_BITS-1:0] cycle_ticks,
	input  logic [pwm_cfg_pkg::NPWM-1:0][pwm_cfg_pkg::PWM_BITS-1:0] on_ticks,
	output logic [pwm_cfg_pkg::NPWM-1:0]         pwm
);

	import pwm_cfg_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per-channel down-counters
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic [NPWM-1:0][PWM_BITS-1:0] cnt;

	// high from reload until the counter meets the compare value,
	// so the compare holds the low time of the period
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			pwm <= '0;
		end else begin
			for (int i = 0; i < NPWM; i++) begin
				if (cnt[i] == '0) begin
					// new cycle length is picked up here
					cnt[i] <= cycle_ticks[i];
					pwm[i] <= 1'b1;
				end else begin
					cnt[i] <= cnt[i] - PWM_BITS'(1);
				end

				// match beats the set, a compare of 0 stays low
				if (cnt[i] == on_ticks[i]) begin
					pwm[i] <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/pwm_channel_regs.sv
`timescale 1ns/1ns
`default_nettype none

module pwm_channel_regs (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic [31:0]                          systime,
	input  logic                                 wr_en,
	input  logic [pwm_cfg_pkg::CH_BITS-1:0]      wr_channel,
	input  pwm_cfg_pkg::cfg_field_e              wr_field,
	input  pwm_cmd_pkg::arg_word_u               wr_data,
	output logic [pwm_cfg_pkg::NPWM-1:0][pwm_cfg_pkg::PWM_BITS-1:0] cycle_ticks,
	output logic [pwm_cfg_pkg::NPWM-1:0][pwm_cfg_pkg::PWM_BITS-1:0] on_ticks
);

	import pwm_cfg_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per-channel state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic [NPWM-1:0]                default_lvl;
	logic [NPWM-1:0][31:0]          max_dur;
	logic [NPWM-1:0][31:0]          next_time;
	logic [NPWM-1:0][PWM_BITS-1:0]  next_on;
	logic [NPWM-1:0]                armed;
	logic [NPWM-1:0][31:0]          dur_cnt;

	// decoded per channel
	logic [NPWM-1:0] wr_sel;
	logic [NPWM-1:0] sched_hit;
	logic [NPWM-1:0] expire;

	always_comb begin
		for (int i = 0; i < NPWM; i++) begin
			// indices past the last channel select nothing
			wr_sel[i]    = wr_en && (wr_channel == CH_BITS'(i));
			sched_hit[i] = armed[i] && (next_time[i] == systime);
			expire[i]    = (dur_cnt[i] == 32'd1);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// writes, safety expiry and schedule load
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// later assignments win: write, then expiry, then schedule load
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cycle_ticks <= '0;
			on_ticks    <= '0;
			default_lvl <= '0;
			max_dur     <= '0;
			next_time   <= '0;
			next_on     <= '0;
			armed       <= '0;
			dur_cnt     <= '0;
		end else begin
			for (int i = 0; i < NPWM; i++) begin
				if (wr_sel[i]) begin
					case (wr_field)
						FIELD_CYCLE: begin
							// counter runs cycle-1 down to 0
							cycle_ticks[i] <= wr_data.ticks.tick - PWM_BITS'(1);
						end
						FIELD_ON: begin
							on_ticks[i] <= wr_data.ticks.tick;
						end
						FIELD_DEFAULT: begin
							default_lvl[i] <= wr_data.raw[0];
						end
						FIELD_MAX_DUR: begin
							max_dur[i] <= wr_data.raw;
						end
						FIELD_NEXT_TIME: begin
							next_time[i] <= wr_data.raw;
						end
						FIELD_NEXT_ON: begin
							next_on[i] <= wr_data.ticks.tick;
							armed[i]   <= 1'b1;
						end
						default: begin
						end
					endcase
				end

				// safety timer, all zeros or all ones gives a steady level
				if (expire[i]) begin
					on_ticks[i] <= {PWM_BITS{default_lvl[i]}};
				end
				if (dur_cnt[i] != 32'd0) begin
					dur_cnt[i] <= dur_cnt[i] - 32'd1;
				end

				// scheduled compare takes effect, restart safety timer
				if (sched_hit[i]) begin
					on_ticks[i] <= next_on[i];
					dur_cnt[i]  <= max_dur[i];
					armed[i]    <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/pwm_cmd_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module pwm_cmd_decoder (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [pwm_cmd_pkg::CMD_BITS-1:0]    cmd,
	input  logic                                cmd_ready,
	input  pwm_cmd_pkg::arg_word_u              arg_data,
	output logic                                cmd_done,
	output logic                                wr_en,
	output logic [pwm_cfg_pkg::CH_BITS-1:0]     wr_channel,
	output pwm_cfg_pkg::cfg_field_e             wr_field,
	output pwm_cmd_pkg::arg_word_u              wr_data
);

	import pwm_cfg_pkg::*;
	import pwm_cmd_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// states, one per expected argument word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic [2:0] ST_IDLE        = 3'd0;
	localparam logic [2:0] ST_CFG_CYCLE   = 3'd1;
	localparam logic [2:0] ST_CFG_ON      = 3'd2;
	localparam logic [2:0] ST_CFG_DEFAULT = 3'd3;
	localparam logic [2:0] ST_CFG_MAX_DUR = 3'd4;
	localparam logic [2:0] ST_SCHED_TIME  = 3'd5;
	localparam logic [2:0] ST_SCHED_ON    = 3'd6;

	logic [2:0] state;

	// sequencing, channel latch and done pulse
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			wr_channel <= '0;
			cmd_done   <= 1'b0;
		end else begin
			cmd_done <= 1'b0;
			case (state)
				ST_IDLE: begin
					// no new command in the done cycle
					if (cmd_ready && !cmd_done) begin
						wr_channel <= arg_data.raw[CH_BITS-1:0];
						if (cmd == CMD_CONFIG_PWM) begin
							state <= ST_CFG_CYCLE;
						end else if (cmd == CMD_SCHEDULE_PWM) begin
							state <= ST_SCHED_TIME;
						end else begin
							// unknown code, acknowledge right away
							cmd_done <= 1'b1;
						end
					end
				end
				ST_CFG_CYCLE: begin
					state <= ST_CFG_ON;
				end
				ST_CFG_ON: begin
					state <= ST_CFG_DEFAULT;
				end
				ST_CFG_DEFAULT: begin
					state <= ST_CFG_MAX_DUR;
				end
				ST_CFG_MAX_DUR: begin
					state    <= ST_IDLE;
					cmd_done <= 1'b1;
				end
				ST_SCHED_TIME: begin
					state <= ST_SCHED_ON;
				end
				ST_SCHED_ON: begin
					state    <= ST_IDLE;
					cmd_done <= 1'b1;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write strobe, one per argument word in the cycle it is present
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		wr_en    = 1'b1;
		wr_field = FIELD_CYCLE;
		case (state)
			ST_CFG_CYCLE:   wr_field = FIELD_CYCLE;
			ST_CFG_ON:      wr_field = FIELD_ON;
			ST_CFG_DEFAULT: wr_field = FIELD_DEFAULT;
			ST_CFG_MAX_DUR: wr_field = FIELD_MAX_DUR;
			ST_SCHED_TIME:  wr_field = FIELD_NEXT_TIME;
			ST_SCHED_ON:    wr_field = FIELD_NEXT_ON;
			default:        wr_en    = 1'b0;
		endcase
	end

	// word goes out untouched, the register block picks the view
	assign wr_data = arg_data;

endmodule

`default_nettype wire

// File: src/pwm_cmd_pkg.sv
`default_nettype none

package pwm_cmd_pkg;

	import pwm_cfg_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// command codes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int CMD_BITS = 8;

	// channel, cycle, on, default, max duration
	localparam logic [CMD_BITS-1:0] CMD_CONFIG_PWM = 8'd2;

	// channel, next time, next on
	localparam logic [CMD_BITS-1:0] CMD_SCHEDULE_PWM = 8'd3;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// argument word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int ARG_BITS = 32;
	localparam int ARG_PAD_BITS = ARG_BITS - PWM_BITS;

	// tick view, upper bits are ignored
	typedef struct packed {
		logic [ARG_PAD_BITS-1:0] pad;
		logic [PWM_BITS-1:0]     tick;
	} arg_ticks_t;

	// raw view is used for times, durations, channel and default level
	typedef union packed {
		logic [ARG_BITS-1:0] raw;
		arg_ticks_t          ticks;
	} arg_word_u;

endpackage

`default_nettype wire

// File: src/pwm_cfg_pkg.sv
`default_nettype none

package pwm_cfg_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// channel bank geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// number of pwm outputs in the bank
	localparam int NPWM = 12;

	// width of the cycle down-counter and of the compare value
	localparam int PWM_BITS = 26;

	// width of a channel index as carried in the first command word
	// (indices 12..15 address nothing)
	localparam int CH_BITS = 4;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register field codes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// tag sent with each write strobe from the decoder
	typedef enum logic [2:0] {
		// cycle length, stored minus one
		FIELD_CYCLE     = 3'd0,
		// compare value in countdown form
		FIELD_ON        = 3'd1,
		// level forced when the safety timer runs out
		FIELD_DEFAULT   = 3'd2,
		// safety timer reload, zero means no timeout
		FIELD_MAX_DUR   = 3'd3,
		// system time at which the scheduled compare loads
		FIELD_NEXT_TIME = 3'd4,
		// scheduled compare, writing it arms the channel
		FIELD_NEXT_ON   = 3'd5
	} cfg_field_e;

endpackage

`default_nettype wire
